// File: files.f
sram_demo_pkg.sv
tick_divider.sv
fill_sequencer.sv
fill_datapath.sv
sram_array.sv
sram_demo_top.sv
tb_sram_demo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# verilator build and run of the sram demo testbench
# the verdict comes from the pass line in sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module tb_sram_demo -f files.f \
	-o tb_sram_demo > build.log 2>&1 \
	&& ./obj_dir/tb_sram_demo > sim.log 2>&1 \
	|| echo "build or simulation returned an error, see build.log and sim.log"

touch sim.log
grep -qx "ALL TESTS PASSED" sim.log \
	&& echo "simulation passed" \
	&& exit 0 \
	|| { echo "simulation failed"; exit 1; }

// File: tb_sram_demo.sv
//==========================================================================
// fast tests settle in 3 clocks; the slow pass alone runs ~28k clocks
//==========================================================================
`default_nettype none

module tb_sram_demo;

	localparam int CLK_PERIOD = 40;
	localparam int WD_CYCLES  = 8 * (384 + 64 * 40 + 64 * 400);  // upper bound on the run
	localparam int SLOW_STEP  = 64;   // clocks per step with sw[8] set
	localparam int FILL_STEPS = 384;  // 128 cells, 3 steps each

	logic       orig_clk;
	logic       rst_n;
	logic [9:0] sw;
	logic [9:0] ledr;

	// check enables, moved on clock edges like the stimulus
	logic fill_chk = 1'b0;
	logic rd_chk   = 1'b0;
	logic slow_chk = 1'b0;
	int   settle   = 2;     // sw_age needed before a readback compare

	// input and output history
	int         cyc      = 0;
	logic [6:0] sw_hold  = '0;   // sw[6:0] seen at the last edge
	int         sw_age   = 0;    // edges since sw[6:0] last moved
	logic [9:0] led_hold = '0;
	int         led_age  = 0;

	int err_cnt   = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int mark      = 0;    // err_cnt at start of current test

	sram_demo_top i_dut (
		.orig_clk (orig_clk),
		.rst_n    (rst_n),
		.sw       (sw),
		.ledr     (ledr)
	);

	initial begin
		orig_clk = 1'b0;
		forever #(CLK_PERIOD / 2) orig_clk = ~orig_clk;
	end

	// watchdog
	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("timeout: run still going after %0d clock periods", WD_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	always @(posedge orig_clk) begin
		cyc <= cyc + 1;
		if (sw[6:0] != sw_hold) begin
			sw_age <= 0;               // new address on the switches
		end else if (sw_age < 1_000_000) begin
			sw_age <= sw_age + 1;
		end
		sw_hold <= sw[6:0];
		if (ledr != led_hold) begin
			led_age <= 0;
		end else if (led_age < 1_000_000) begin
			led_age <= led_age + 1;
		end
		led_hold <= ledr;
	end

	// leds dark in reset and on the first step after release
	a_reset_dark: assert property (@(posedge orig_clk)
		(cyc > 1 && (!rst_n || !$past(rst_n))) |-> ledr == 10'd0)
	else begin
		err_cnt++;
		$display("Fail at %0t: ledr = %h around reset", $time, $sampled(ledr));
	end

	a_upper_zero: assert property (@(posedge orig_clk)
		(cyc > 1) |-> ledr[9:7] == 3'b000)
	else begin
		err_cnt++;
		$display("Fail at %0t: ledr[9:7] = %b", $time, $sampled(ledr[9:7]));
	end

	// fill shows 127 first
	a_fill_start: assert property (@(posedge orig_clk) disable iff (!rst_n)
		$rose(fill_chk) |-> ledr[6:0] == 7'd127)
	else begin
		err_cnt++;
		$display("Fail at %0t: fill starts at %0d", $time, $sampled(ledr[6:0]));
	end

	// ... then never climbs
	a_fill_desc: assert property (@(posedge orig_clk) disable iff (!rst_n)
		(fill_chk && $past(fill_chk)) |-> ledr[6:0] <= $past(ledr[6:0]))
	else begin
		err_cnt++;
		$display("Fail at %0t: fill value rose to %0d", $time, $sampled(ledr[6:0]));
	end

	// cell a holds 127 - a once the address has been still long enough
	a_readback: assert property (@(posedge orig_clk) disable iff (!rst_n)
		(rd_chk && sw[6:0] == sw_hold && sw_age >= settle)
		|-> ledr[6:0] == (7'd127 - sw[6:0]))
	else begin
		err_cnt++;
		$display("Fail at %0t: addr %0d read %0d", $time, $sampled(sw[6:0]),
			$sampled(ledr[6:0]));
	end

	// slow mode: one led change per 64 clocks at most
	a_slow_rate: assert property (@(posedge orig_clk) disable iff (!rst_n)
		(slow_chk && ledr != led_hold) |-> led_age >= SLOW_STEP - 1)
	else begin
		err_cnt++;
		$display("Fail at %0t: ledr moved after %0d clocks", $time, $sampled(led_age) + 1);
	end

	// one result line per test
	task automatic end_test(input string name);
		tests_run++;
		if (err_cnt == mark) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_bad++;
			$display("test %0d %s: %0d check(s) failed", tests_run, name, err_cnt - mark);
		end
		mark = err_cnt;
	endtask

	// corners 0 and 127 first, then random cells
	task automatic read_back(input int n_addr, input int hold, input int need);
		logic [6:0] a;
		@(posedge orig_clk);
		settle <= need;
		rd_chk <= 1'b1;
		for (int i = 0; i < n_addr; i++) begin
			if (i == 0) begin
				a = 7'd0;
			end else if (i == 1) begin
				a = 7'd127;
			end else begin
				a = 7'($urandom % 128);
			end
			sw[6:0] <= a;
			repeat (hold) @(posedge orig_clk);
		end
		rd_chk <= 1'b0;   // last compare is on this edge
		@(negedge orig_clk);
	endtask

	initial begin
		void'($urandom(32'h245c_0fe9));
		rst_n <= 1'b0;
		sw    <= '0;

		// reset held 16 clocks
		repeat (16) @(posedge orig_clk);
		rst_n <= 1'b1;
		@(posedge orig_clk);       // first step, leds still dark
		fill_chk <= 1'b1;
		@(negedge orig_clk);
		end_test("reset state");

		repeat (FILL_STEPS) @(posedge orig_clk);
		fill_chk <= 1'b0;
		repeat (8) @(posedge orig_clk);   // read pipe primes
		@(negedge orig_clk);
		end_test("fill display");

		read_back(64, 4, 2);
		end_test("readback");

		// restart pulse from the read state
		@(posedge orig_clk);
		sw[9] <= 1'b1;
		@(posedge orig_clk);       // DUT restarts here
		sw[9] <= 1'b0;
		@(posedge orig_clk);
		fill_chk <= 1'b1;
		repeat (FILL_STEPS) @(posedge orig_clk);
		fill_chk <= 1'b0;
		repeat (8) @(posedge orig_clk);
		read_back(16, 4, 2);
		end_test("restart");

		// slow mode, restart held one step window
		@(posedge orig_clk);
		sw[8] <= 1'b1;
		sw[9] <= 1'b1;
		repeat (SLOW_STEP) @(posedge orig_clk);
		sw[9] <= 1'b0;
		repeat (SLOW_STEP) @(posedge orig_clk);
		slow_chk <= 1'b1;
		repeat ((FILL_STEPS + 3) * SLOW_STEP) @(posedge orig_clk);  // fill plus read pipe
		read_back(8, 5 * SLOW_STEP, 250);
		slow_chk <= 1'b0;
		end_test("slow rate");

		$display("%0d tests run, %0d with errors, %0d failed checks",
			tests_run, tests_bad, err_cnt);
		if (err_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sram_demo_top.sv
//==========================================================================
// single clock orig_clk; sw[9] restart, sw[8] slow, sw[6:0] read address
//==========================================================================
`default_nettype none

module sram_demo_top import sram_demo_pkg::*; (
	input  logic       orig_clk,
	input  logic       rst_n,
	input  logic [9:0] sw,
	output logic [9:0] ledr
);

	logic      step;
	logic      cs_n, oe_n, rw;
	logic      advance, load_read, reading;
	logic      last_cell;
	sram_cmd_t cmd;
	word_t     rdata;

	tick_divider i_div (
		.orig_clk (orig_clk),
		.rst_n    (rst_n),
		.slow     (sw[8]),
		.step     (step)
	);

	fill_sequencer i_seq (
		.orig_clk  (orig_clk),
		.rst_n     (rst_n),
		.step      (step),
		.restart   (sw[9]),
		.last_cell (last_cell),
		.cs_n      (cs_n),
		.oe_n      (oe_n),
		.rw        (rw),
		.advance   (advance),
		.load_read (load_read),
		.reading   (reading)
	);

	fill_datapath i_dp (
		.orig_clk  (orig_clk),
		.rst_n     (rst_n),
		.step      (step),
		.restart   (sw[9]),
		.advance   (advance),
		.load_read (load_read),
		.reading   (reading),
		.sel_addr  (sw[6:0]),
		.cs_n      (cs_n),
		.oe_n      (oe_n),
		.rw        (rw),
		.rdata     (rdata),
		.cmd       (cmd),
		.last_cell (last_cell),
		.ledr      (ledr)
	);

	sram_array i_mem (
		.orig_clk (orig_clk),
		.rst_n    (rst_n),
		.step     (step),
		.cmd      (cmd),
		.rdata    (rdata)
	);

endmodule

`default_nettype wire

// File: sram_array.sv
//==========================================================================
// behavioral sram on the step enable; no pin timing, contents not reset
//==========================================================================
`default_nettype none

module sram_array import sram_demo_pkg::*; (
	input  logic      orig_clk,
	input  logic      rst_n,
	input  logic      step,
	input  sram_cmd_t cmd,
	output word_t     rdata   // valid one step after the read
);

	word_t mem [0:MEM_DEPTH-1];  // 128 x 7 storage
	logic  wr_en;
	logic  rd_en;

	// decode of the active-low controls
	assign wr_en = step && !cmd.cs_n && !cmd.rw;
	assign rd_en = step && !cmd.cs_n && cmd.rw && !cmd.oe_n;

	// write port
	always_ff @(posedge orig_clk) begin
		if (wr_en) begin
			mem[cmd.addr] <= cmd.wdata;
		end
	end

	// registered read port
	always_ff @(posedge orig_clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (rd_en) begin
			rdata <= mem[cmd.addr];
		end
		// otherwise hold last word, like a latched bus
	end

	// a real part would fight its own driver if oe_n were low in a write,
	// so the sequencer must keep the outputs off across the whole write
	a_oe_off_in_write: assert property (
		@(posedge orig_clk) disable iff (!rst_n)
		(!cmd.cs_n && !cmd.rw) |-> cmd.oe_n
	) else $error("sram_array: output enable low during write");

endmodule

`default_nettype wire

// File: fill_datapath.sv
//==========================================================================
// address and value move together; last cell holds, no wrap to address 0
//==========================================================================
`default_nettype none

module fill_datapath import sram_demo_pkg::*; (
	input  logic      orig_clk,
	input  logic      rst_n,
	input  logic      step,
	input  logic      restart,
	input  logic      advance,
	input  logic      load_read,
	input  logic      reading,
	input  addr_t     sel_addr,   // sw[6:0]
	input  logic      cs_n,
	input  logic      oe_n,
	input  logic      rw,
	input  word_t     rdata,
	output sram_cmd_t cmd,
	output logic      last_cell,
	output logic [9:0] ledr
);

	addr_t addr_q;   // current cell
	word_t value_q;  // 127 - addr_q during fill
	word_t led_q;    // registered display

	always_ff @(posedge orig_clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_q  <= '0;
			value_q <= VALUE_START;
			led_q   <= '0;
		end else if (step) begin
			if (restart) begin
				addr_q  <= '0;
				value_q <= VALUE_START;
				led_q   <= '0;
			end else begin
				if (advance && !last_cell) begin
					addr_q  <= addr_q + 7'd1;
					value_q <= value_q - 7'd1;  // stays paired with addr
				end else if (load_read) begin
					addr_q <= sel_addr;  // follow switches each step
				end
				led_q <= reading ? rdata : value_q;  // fill value or readback
			end
		end
	end

	assign last_cell = (addr_q == ADDR_LAST);

	// controls from the sequencer, payload from here
	assign cmd = '{cs_n: cs_n, oe_n: oe_n, rw: rw, addr: addr_q, wdata: value_q};

	assign ledr = {3'b000, led_q};  // upper leds unused

	// descending pattern: every written pair sums to 127
	a_pair_sum: assert property (
		@(posedge orig_clk) disable iff (!rst_n)
		advance |-> (8'(addr_q) + 8'(value_q) == 8'(ADDR_LAST))
	) else $error("fill_datapath: address and value out of step");

endmodule

`default_nettype wire

// File: fill_sequencer.sv
//==========================================================================
// write/advance/check per cell, then parks in read until restart or reset
//==========================================================================
`default_nettype none

module fill_sequencer import sram_demo_pkg::*; (
	input  logic orig_clk,
	input  logic rst_n,
	input  logic step,       // state moves only here
	input  logic restart,    // sw[9], synchronous
	input  logic last_cell,  // address is at ADDR_LAST
	output logic cs_n,
	output logic oe_n,
	output logic rw,
	output logic advance,    // bump address, drop value
	output logic load_read,  // take address from switches
	output logic reading     // led shows memory, not fill value
);

	seq_state_t state;
	logic       last_wr;  // cell just written was ADDR_LAST

	always_ff @(posedge orig_clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_write;
			cs_n    <= 1'b1;  // memory idle
			oe_n    <= 1'b1;
			rw      <= 1'b1;
			last_wr <= 1'b0;
		end else if (step) begin
			if (restart) begin
				// same as reset, fill from cell 0
				state   <= st_write;
				cs_n    <= 1'b1;
				oe_n    <= 1'b1;
				rw      <= 1'b1;
				last_wr <= 1'b0;
			end else begin
				case (state)
					st_write: begin
						// write command, memory takes it next step
						cs_n  <= 1'b0;
						rw    <= 1'b0;
						oe_n  <= 1'b1;  // keep the outputs off while writing
						state <= st_advance;
					end

					st_advance: begin
						// write lands on this edge, then release the part
						cs_n    <= 1'b1;
						rw      <= 1'b1;
						last_wr <= last_cell;  // address not bumped yet
						state   <= st_check;
					end

					st_check: begin
						if (last_wr) begin
							cs_n  <= 1'b0;  // switch to read for good
							rw    <= 1'b1;
							oe_n  <= 1'b0;
							state <= st_read;
						end else begin
							state <= st_write;  // next cell
						end
					end

					st_read: begin
						// controls stay on read, address comes from datapath
						state <= st_read;
					end

					default: state <= st_write;
				endcase
			end
		end
	end

	// strobes carry step so the datapath sees one clock each
	assign advance   = step && (state == st_advance);
	assign load_read = step && (state == st_read);
	assign reading   = (state == st_read);

	// no write may reach the memory once readback has started
	a_no_write_in_read: assert property (
		@(posedge orig_clk) disable iff (!rst_n)
		(state == st_read) |-> !(!cs_n && !rw)
	) else $error("fill_sequencer: write command in read state");

endmodule

`default_nettype wire

// File: tick_divider.sv
//==========================================================================
// produces a step enable, not a clock; fast mode steps on every clock
//==========================================================================
`default_nettype none

module tick_divider import sram_demo_pkg::*; (
	input  logic orig_clk,
	input  logic rst_n,
	input  logic slow,   // sw[8]
	output logic step    // one-clock enable
);

	logic [DIV_WIDTH-1:0] div_cnt;  // free-running count
	logic                 wrap;     // low bits about to roll over

	always_ff @(posedge orig_clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;  // never stops, never cleared by sw[9]
		end
	end

	// carry out of the low bits, i.e. all ones right now
	assign wrap = &div_cnt[SLOW_DIV_BIT-1:0];

	// fast is constant high
	assign step = slow ? wrap : 1'b1;

	// slow strobe must be a single clock wide
	a_slow_single: assert property (
		@(posedge orig_clk) disable iff (!rst_n)
		(slow && step) |=> !(slow && step)
	) else $error("tick_divider: slow step held for two clocks");

endmodule

`default_nettype wire

// File: sram_demo_pkg.sv
//==========================================================================
// shared widths, constants and types; memory is 128 x 7, no parity
//==========================================================================
`default_nettype none

package sram_demo_pkg;

	// sram geometry
	typedef logic [6:0] addr_t;   // word address
	typedef logic [6:0] word_t;   // data word

	localparam int MEM_DEPTH = 128;          // cells in the array
	localparam addr_t ADDR_LAST = 7'd127;    // final cell of the fill
	localparam word_t VALUE_START = 7'd127;  // written at address 0

	// step rate
	localparam int DIV_WIDTH = 32;   // free-running divider width
	// slow mode steps once per 2^6 clocks
	// a board build would move this up to around 20
	localparam int SLOW_DIV_BIT = 6;

	// sequencer states, same codes as the old 2-bit state reg
	typedef enum logic [1:0] {
		st_write   = 2'b00,  // issue write of current cell
		st_advance = 2'b01,  // bump address, drop value
		st_check   = 2'b10,  // loop or go to read
		st_read    = 2'b11   // follow the switches forever
	} seq_state_t;

	// one sram access, controls are active low like the part
	typedef struct packed {
		logic  cs_n;   // chip select
		logic  oe_n;   // output enable
		logic  rw;     // 1 read, 0 write
		addr_t addr;   // word address
		word_t wdata;  // write data
	} sram_cmd_t;    // 17 bits

endpackage

`default_nettype wire
